// ==== design/debayer_pkg.sv ====
package debayer_pkg;

	localparam int PIXEL_WIDTH  = 10;	// raw and colour sample width
	localparam int PIX_PER_BEAT = 2;	// one bayer pair per beat
	localparam int ADDR_W       = 10;	// up to 1024 beats per line

	typedef logic [PIXEL_WIDTH-1:0] pixel_t;
	typedef pixel_t [PIX_PER_BEAT-1:0] pair_t;	// slot 0 holds the even column
	typedef logic [1:0] slot_t;	// line ram index

	typedef enum logic {
		ROW_BG = 1'b0,	// even row, B G B G
		ROW_GR = 1'b1	// odd row, G R G R
	} row_kind_e;

	typedef enum logic [1:0] {
		FILL_EMPTY = 2'd0,
		FILL_ONE   = 2'd1,
		FILL_READY = 2'd2	// centre row has a line above and below
	} fill_state_e;

	typedef struct packed {
		logic  valid;
		logic  sof;	// column 0 of row 0
		pair_t pix;
	} bayer_beat_t;

	typedef struct packed {
		logic              valid;
		logic              emit;	// centre row goes to the output
		logic              first;
		logic              last;
		row_kind_e         row_kind;	// kind of the centre row
		slot_t             slot_wr;
		slot_t             slot_above;
		slot_t             slot_center;
		logic [ADDR_W-1:0] addr;
		pair_t             pix;
	} wr_cmd_t;

	typedef struct packed {
		logic      valid;
		logic      emit;
		logic      first;
		logic      last;
		row_kind_e row_kind;
		pair_t     above;
		pair_t     center;
		pair_t     below;
	} line_taps_t;

	typedef struct packed {
		pixel_t r;
		pixel_t g;
		pixel_t b;
	} rgb_t;

	typedef struct packed {
		logic                    valid;
		rgb_t [PIX_PER_BEAT-1:0] pix;
	} rgb_beat_t;

endpackage

// ==== design/line_writer.sv ====
`timescale 1ns/10ps

module line_writer #(
	parameter int LINE_BEATS = 640
) (
	input  logic                     clk_i,
	input  logic                     line_valid_i,	// async reset, active high
	input  debayer_pkg::bayer_beat_t bayer_i,
	output debayer_pkg::wr_cmd_t     cmd_o
);

	import debayer_pkg::*;

	localparam logic [ADDR_W-1:0] LAST_BEAT = ADDR_W'(LINE_BEATS - 1);

	logic [ADDR_W-1:0] beat_cnt_q;
	slot_t             slot_wr_q;
	slot_t             slot_center_q;	// previous line
	slot_t             slot_above_q;	// line before that
	row_kind_e         row_kind_q;	// parity of the row being written
	fill_state_e       fill_q;

	logic [ADDR_W-1:0] beat_eff;
	row_kind_e         row_kind_eff;
	fill_state_e       fill_eff;
	logic              line_end;

	logic              cmd_vld_q;
	wr_cmd_t           cmd_pay_q;

	// a sof beat is already beat 0 of row 0
	always_comb
	begin
		beat_eff     = bayer_i.sof ? '0 : beat_cnt_q;
		row_kind_eff = bayer_i.sof ? ROW_BG : row_kind_q;
		fill_eff     = bayer_i.sof ? FILL_EMPTY : fill_q;
		line_end     = (beat_eff == LAST_BEAT);
	end

	always_ff @(posedge clk_i or posedge line_valid_i)
	begin
		if (line_valid_i)
		begin
			beat_cnt_q    <= '0;
			slot_wr_q     <= 2'd0;
			slot_center_q <= 2'd1;
			slot_above_q  <= 2'd2;
			row_kind_q    <= ROW_BG;
			fill_q        <= FILL_EMPTY;
		end
		else if (bayer_i.valid)
		begin
			if (line_end)
			begin
				beat_cnt_q    <= '0;
				slot_wr_q     <= slot_above_q;	// oldest line is overwritten next
				slot_center_q <= slot_wr_q;
				slot_above_q  <= slot_center_q;
				row_kind_q    <= (row_kind_eff == ROW_BG) ? ROW_GR : ROW_BG;
				fill_q        <= (fill_eff == FILL_EMPTY) ? FILL_ONE : FILL_READY;
			end
			else
			begin
				beat_cnt_q <= beat_eff + 1'b1;
				row_kind_q <= row_kind_eff;
				fill_q     <= fill_eff;
			end
		end
	end

	always_ff @(posedge clk_i or posedge line_valid_i)
	begin
		if (line_valid_i)
			cmd_vld_q <= 1'b0;
		else
			cmd_vld_q <= bayer_i.valid;
	end

	always_ff @(posedge clk_i)
	begin
		if (bayer_i.valid)
		begin
			cmd_pay_q.valid       <= 1'b1;
			cmd_pay_q.emit        <= (fill_eff == FILL_READY);
			cmd_pay_q.first       <= (beat_eff == '0);
			cmd_pay_q.last        <= line_end;
			cmd_pay_q.row_kind    <= (row_kind_eff == ROW_BG) ? ROW_GR : ROW_BG;	// centre row
			cmd_pay_q.slot_wr     <= slot_wr_q;
			cmd_pay_q.slot_above  <= slot_above_q;
			cmd_pay_q.slot_center <= slot_center_q;
			cmd_pay_q.addr        <= beat_eff;
			cmd_pay_q.pix         <= bayer_i.pix;
		end
	end

	always_comb
	begin
		cmd_o       = cmd_pay_q;
		cmd_o.valid = cmd_vld_q;
	end

	// the idle beat after a line lets the interpolator flush its last beat
	a_line_gap: assert property (@(posedge clk_i) disable iff (line_valid_i)
		bayer_i.valid && line_end |=> !bayer_i.valid);

endmodule

// ==== design/line_buffer.sv ====
`timescale 1ns/10ps

module line_buffer #(
	parameter int LINE_BEATS = 640
) (
	input  logic                    clk_i,
	input  debayer_pkg::wr_cmd_t    cmd_i,
	output debayer_pkg::line_taps_t taps_o
);

	import debayer_pkg::*;

	localparam int NUM_SLOTS = 3;
	localparam int RAM_AW    = (LINE_BEATS > 1) ? $clog2(LINE_BEATS) : 1;

	logic [RAM_AW-1:0] ram_addr;
	pair_t             rd_q [NUM_SLOTS];	// registered ram read data

	logic              valid_q;
	logic              emit_q;
	logic              first_q;
	logic              last_q;
	row_kind_e         row_kind_q;
	slot_t             above_sel_q;
	slot_t             center_sel_q;
	pair_t             below_q;	// current input bypasses the rams

	assign ram_addr = cmd_i.addr[RAM_AW-1:0];

	// one line ram per slot, read and write share the address
	for (genvar s = 0; s < NUM_SLOTS; s++)
	begin : g_slot
		pair_t mem [LINE_BEATS];

		always_ff @(posedge clk_i)
		begin
			if (cmd_i.valid && (cmd_i.slot_wr == slot_t'(s)))
				mem[ram_addr] <= cmd_i.pix;
			rd_q[s] <= mem[ram_addr];
		end
	end

	// flags travel alongside the ram read
	always_ff @(posedge clk_i)
	begin
		valid_q    <= cmd_i.valid;
		emit_q     <= cmd_i.emit;
		first_q    <= cmd_i.first;
		last_q     <= cmd_i.last;
		row_kind_q <= cmd_i.row_kind;
	end

	always_ff @(posedge clk_i)
	begin
		if (cmd_i.valid)
		begin
			above_sel_q  <= cmd_i.slot_above;
			center_sel_q <= cmd_i.slot_center;
			below_q      <= cmd_i.pix;
		end
	end

	always_comb
	begin
		taps_o.valid    = valid_q;
		taps_o.emit     = emit_q;
		taps_o.first    = first_q;
		taps_o.last     = last_q;
		taps_o.row_kind = row_kind_q;
		taps_o.above    = rd_q[above_sel_q];
		taps_o.center   = rd_q[center_sel_q];
		taps_o.below    = below_q;
	end

	// the writer rotation must never write a line that is being read
	a_slot_distinct: assert property (@(posedge clk_i)
		cmd_i.valid |-> (cmd_i.slot_wr != cmd_i.slot_above) &&
			(cmd_i.slot_wr != cmd_i.slot_center) &&
			(cmd_i.slot_above != cmd_i.slot_center));

endmodule

// ==== design/bayer_interp.sv ====
`timescale 1ns/10ps

module bayer_interp (
	input  logic                    clk_i,
	input  logic                    line_valid_i,	// async reset, active high
	input  debayer_pkg::line_taps_t taps_i,
	output debayer_pkg::rgb_beat_t  rgb_o
);

	import debayer_pkg::*;

	line_taps_t win_prev_q;
	line_taps_t win_cur_q;	// beat being interpolated
	line_taps_t win_nxt_q;
	logic       nxt_vld_q;
	logic       pending_q;	// window holds a complete beat
	logic       flush;
	logic       shift;
	logic       tap_emit;

	pixel_t     a_l;
	pixel_t     a_r;
	pixel_t     c_l;
	pixel_t     c_r;
	pixel_t     b_l;
	pixel_t     b_r;
	rgb_t       rgb_even;
	rgb_t       rgb_odd;

	logic                    rgb_vld_q;
	rgb_t [PIX_PER_BEAT-1:0] rgb_pay_q;

	function automatic pixel_t avg2(input pixel_t x, input pixel_t y);
		logic [PIXEL_WIDTH:0] sum;
		sum = {1'b0, x} + {1'b0, y};
		return sum[PIXEL_WIDTH:1];	// rounds down
	endfunction

	function automatic pixel_t avg4(input pixel_t w, input pixel_t x,
		input pixel_t y, input pixel_t z);
		logic [PIXEL_WIDTH+1:0] sum;
		sum = {2'b00, w} + {2'b00, x} + {2'b00, y} + {2'b00, z};
		return sum[PIXEL_WIDTH+1:2];
	endfunction

	// colour site is B on a BG row and R on a GR row, else a G site
	function automatic rgb_t site_rgb(
		input row_kind_e kind,
		input logic      colour_site,
		input pixel_t    al, input pixel_t ac, input pixel_t ar,
		input pixel_t    cl, input pixel_t cc, input pixel_t cr,
		input pixel_t    bl, input pixel_t bc, input pixel_t br
	);
		rgb_t   px;
		pixel_t other;
		pixel_t horiz;
		pixel_t vert;
		other = avg4(al, ar, bl, br);	// diagonals
		horiz = avg2(cl, cr);
		vert  = avg2(ac, bc);
		if (colour_site)
		begin
			px.g = avg4(cl, cr, ac, bc);	// cross neighbours
			px.b = (kind == ROW_BG) ? cc : other;
			px.r = (kind == ROW_BG) ? other : cc;
		end
		else
		begin
			px.g = cc;
			px.b = (kind == ROW_BG) ? horiz : vert;
			px.r = (kind == ROW_BG) ? vert : horiz;
		end
		return px;
	endfunction

	assign tap_emit = taps_i.valid && taps_i.emit;
	assign flush    = nxt_vld_q && win_nxt_q.last;	// the idle beat after a line
	assign shift    = taps_i.valid || flush;

	always_ff @(posedge clk_i)
	begin
		if (shift)
		begin
			win_prev_q <= win_cur_q;
			win_cur_q  <= win_nxt_q;
			win_nxt_q  <= taps_i;
		end
	end

	always_ff @(posedge clk_i or posedge line_valid_i)
	begin
		if (line_valid_i)
		begin
			nxt_vld_q <= 1'b0;
			pending_q <= 1'b0;
			rgb_vld_q <= 1'b0;
		end
		else
		begin
			nxt_vld_q <= taps_i.valid || (nxt_vld_q && !flush);
			// a first tap means the old line is gone, cut lines lose their tail
			pending_q <= shift && nxt_vld_q && !(taps_i.valid && taps_i.first);
			rgb_vld_q <= pending_q && win_cur_q.emit;
		end
	end

	// edge columns mirror the pixel two columns inward
	always_comb
	begin
		a_l = win_cur_q.first ? win_cur_q.above[1] : win_prev_q.above[1];
		c_l = win_cur_q.first ? win_cur_q.center[1] : win_prev_q.center[1];
		b_l = win_cur_q.first ? win_cur_q.below[1] : win_prev_q.below[1];
		a_r = win_cur_q.last ? win_cur_q.above[0] : win_nxt_q.above[0];
		c_r = win_cur_q.last ? win_cur_q.center[0] : win_nxt_q.center[0];
		b_r = win_cur_q.last ? win_cur_q.below[0] : win_nxt_q.below[0];

		rgb_even = site_rgb(win_cur_q.row_kind, win_cur_q.row_kind == ROW_BG,
			a_l, win_cur_q.above[0], win_cur_q.above[1],
			c_l, win_cur_q.center[0], win_cur_q.center[1],
			b_l, win_cur_q.below[0], win_cur_q.below[1]);
		rgb_odd = site_rgb(win_cur_q.row_kind, win_cur_q.row_kind == ROW_GR,
			win_cur_q.above[0], win_cur_q.above[1], a_r,
			win_cur_q.center[0], win_cur_q.center[1], c_r,
			win_cur_q.below[0], win_cur_q.below[1], b_r);
	end

	always_ff @(posedge clk_i)
	begin
		if (pending_q)
		begin
			rgb_pay_q[0] <= rgb_even;
			rgb_pay_q[1] <= rgb_odd;
		end
	end

	always_comb
	begin
		rgb_o.valid = rgb_vld_q;
		rgb_o.pix   = rgb_pay_q;
	end

	// output follows the right-neighbour tap by two cycles, or the flush by three
	a_emit_only: assert property (@(posedge clk_i) disable iff (line_valid_i)
		rgb_o.valid |-> $past(tap_emit, 2) || $past(tap_emit, 3));

endmodule

// ==== design/debayer_top.sv ====
`timescale 1ns/10ps

module debayer_top #(
	parameter int LINE_BEATS = 640
) (
	input  logic                     clk_i,
	input  logic                     line_valid_i,	// async reset, active high
	input  debayer_pkg::bayer_beat_t bayer_i,
	output debayer_pkg::rgb_beat_t   rgb_o
);

	import debayer_pkg::*;

	wr_cmd_t    cmd;	// writer to line rams
	line_taps_t taps;	// three rows at one column pair

	line_writer #(
		.LINE_BEATS (LINE_BEATS)
	) u_writer (
		.clk_i        (clk_i),
		.line_valid_i (line_valid_i),
		.bayer_i      (bayer_i),
		.cmd_o        (cmd)
	);

	line_buffer #(
		.LINE_BEATS (LINE_BEATS)
	) u_buffer (
		.clk_i  (clk_i),
		.cmd_i  (cmd),
		.taps_o (taps)
	);

	bayer_interp u_interp (
		.clk_i        (clk_i),
		.line_valid_i (line_valid_i),
		.taps_i       (taps),
		.rgb_o        (rgb_o)
	);

endmodule

// ==== dv/debayer_ref.svh ====
`ifndef DEBAYER_REF_SVH
`define DEBAYER_REF_SVH

localparam int REF_COLS     = 2 * LINE_BEATS;	// pixels per row
localparam int REF_MAX_ROWS = 8;

typedef struct packed {
	rgb_t [PIX_PER_BEAT-1:0] pix;	// slot 0 is the even column
	logic [7:0]              row;
	logic [7:0]              beat;
} exp_beat_t;

pixel_t    frame_pix [REF_MAX_ROWS][REF_COLS];	// raw frame as sent to the DUT
exp_beat_t exp_q [$];	// expected output beats, oldest first

// a column outside the row is taken two columns inward
function automatic int raw_at(input int r, input int c);
	int cm;
	cm = c;
	if (cm < 0)
		cm = -cm;
	if (cm >= REF_COLS)
		cm = 2 * REF_COLS - 2 - cm;
	return int'(frame_pix[r][cm]);
endfunction

function automatic rgb_t expected_rgb(input int r, input int c);
	rgb_t px;
	int   self_v;
	int   horiz_v;
	int   vert_v;
	int   cross_v;
	int   diag_v;
	self_v  = raw_at(r, c);
	horiz_v = (raw_at(r, c - 1) + raw_at(r, c + 1)) / 2;
	vert_v  = (raw_at(r - 1, c) + raw_at(r + 1, c)) / 2;
	cross_v = (raw_at(r, c - 1) + raw_at(r, c + 1) + raw_at(r - 1, c) + raw_at(r + 1, c)) / 4;
	diag_v  = (raw_at(r - 1, c - 1) + raw_at(r - 1, c + 1) +
		raw_at(r + 1, c - 1) + raw_at(r + 1, c + 1)) / 4;
	if ((r % 2) == 0 && (c % 2) == 0)
	begin
		px.b = pixel_t'(self_v);	// B site
		px.g = pixel_t'(cross_v);
		px.r = pixel_t'(diag_v);
	end
	else if ((r % 2) == 0)
	begin
		px.g = pixel_t'(self_v);	// G site between B pixels
		px.b = pixel_t'(horiz_v);
		px.r = pixel_t'(vert_v);
	end
	else if ((c % 2) == 0)
	begin
		px.g = pixel_t'(self_v);	// G site between R pixels
		px.r = pixel_t'(horiz_v);
		px.b = pixel_t'(vert_v);
	end
	else
	begin
		px.r = pixel_t'(self_v);	// R site
		px.g = pixel_t'(cross_v);
		px.b = pixel_t'(diag_v);
	end
	return px;
endfunction

// rows 0 and rows_sent-1 have no line above or below
task automatic push_expected(input int rows_sent);
	exp_beat_t e;
	for (int r = 1; r < rows_sent - 1; r++)
	begin
		for (int b = 0; b < LINE_BEATS; b++)
		begin
			e.pix[0] = expected_rgb(r, 2 * b);
			e.pix[1] = expected_rgb(r, 2 * b + 1);
			e.row    = 8'(r);
			e.beat   = 8'(b);
			exp_q.push_back(e);
		end
	end
endtask

`endif

// ==== dv/debayer_tb.sv ====
`timescale 1ns/10ps

module debayer_tb;

	import debayer_pkg::*;

	localparam int LINE_BEATS  = 8;
	localparam int CLK_PERIOD  = 100;
	localparam int MAX_IDLE    = 2;	// idle cycles before a beat, at most
	localparam int MAX_GAP     = 4;	// idle cycles between lines, at most
	localparam int TOTAL_ROWS  = 6 + 4 + 5 + 6 + 4 + 5;
	localparam int TOTAL_BEATS = TOTAL_ROWS * LINE_BEATS;
	localparam int WATCHDOG_CYCLES =
		(TOTAL_BEATS * (1 + MAX_IDLE) + TOTAL_ROWS * MAX_GAP + 8) * 2 + 100;

	logic        clk_i;
	logic        line_valid_i;
	bayer_beat_t bayer_i;
	rgb_beat_t   rgb_o;

	logic [31:0] rng_state;
	int          out_count = 0;	// also indexes the next expected beat
	int          expected_total;

	`include "debayer_ref.svh"

	debayer_top #(
		.LINE_BEATS (LINE_BEATS)
	) u_dut (
		.clk_i        (clk_i),
		.line_valid_i (line_valid_i),
		.bayer_i      (bayer_i),
		.rgb_o        (rgb_o)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic expected_available();
		return out_count < exp_q.size();
	endfunction

	function automatic logic front_matches(input rgb_beat_t got);
		if (out_count >= exp_q.size())
			return 1'b0;
		return got.pix == exp_q[out_count].pix;
	endfunction

	task automatic fill_random(input int rows);
		for (int r = 0; r < rows; r++)
			for (int c = 0; c < REF_COLS; c++)
				frame_pix[r][c] = pixel_t'(next_random());
	endtask

	task automatic fill_flat(input int rows, input pixel_t value);
		for (int r = 0; r < rows; r++)
			for (int c = 0; c < REF_COLS; c++)
				frame_pix[r][c] = value;
	endtask

	// steep enough that a wrong edge column shows up in every channel
	task automatic fill_ramp(input int rows);
		for (int r = 0; r < rows; r++)
			for (int c = 0; c < REF_COLS; c++)
				frame_pix[r][c] = pixel_t'(c * 60 + r);
	endtask

	task automatic drive_idle(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk_i);
			bayer_i <= '0;
		end
	endtask

	task automatic drive_beat(input logic sof, input pair_t pix);
		bayer_beat_t beat;
		beat.valid = 1'b1;
		beat.sof   = sof;
		beat.pix   = pix;
		@(negedge clk_i);
		bayer_i <= beat;
	endtask

	// jitter adds idle beats inside lines and longer gaps between them
	task automatic send_frame(input int rows, input logic jitter);
		pair_t pix;
		push_expected(rows);
		expected_total += (rows - 2) * LINE_BEATS;
		for (int r = 0; r < rows; r++)
		begin
			for (int b = 0; b < LINE_BEATS; b++)
			begin
				if (jitter && (next_random() % 32'd4) == 32'd0)
					drive_idle(1 + int'(next_random() % 32'(MAX_IDLE)));
				pix[0] = frame_pix[r][2 * b];
				pix[1] = frame_pix[r][2 * b + 1];
				drive_beat(r == 0 && b == 0, pix);
			end
			drive_idle(jitter ? 1 + int'(next_random() % 32'(MAX_GAP)) : 1);
		end
	endtask

	always @(posedge clk_i)
	begin
		if (!line_valid_i && rgb_o.valid)
			out_count <= out_count + 1;
	end

	a_no_extra: assert property (@(negedge clk_i) disable iff (line_valid_i)
		rgb_o.valid |-> expected_available())
	else
	begin
		$display("output %0d at %0t ns arrived with no expected beat left", out_count, $time);
		$display("TEST RESULT: FAIL");
		$fatal(1, "unexpected output beat");
	end

	a_match: assert property (@(negedge clk_i) disable iff (line_valid_i)
		rgb_o.valid && expected_available() |-> front_matches(rgb_o))
	else
	begin
		$display("Fail at %0t ns: row %0d beat %0d got %h expected %h", $time,
			exp_q[out_count].row, exp_q[out_count].beat, rgb_o.pix, exp_q[out_count].pix);
		$display("TEST RESULT: FAIL");
		$fatal(1, "output mismatch");
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout after %0d cycles with %0d outputs seen", WATCHDOG_CYCLES, out_count);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		clk_i          = 1'b0;
		line_valid_i   = 1'b1;
		bayer_i        = '0;
		rng_state      = 32'h1cb6_8409;
		expected_total = 0;
		repeat (2) @(negedge clk_i);
		line_valid_i = 1'b0;
		drive_idle(3);

		fill_random(6);
		send_frame(6, 1'b0);
		fill_flat(4, 10'h2a5);
		send_frame(4, 1'b0);
		fill_ramp(5);
		send_frame(5, 1'b0);
		fill_random(6);
		send_frame(6, 1'b1);
		fill_random(7);
		send_frame(4, 1'b1);	// next sof cuts this frame after four of seven rows
		fill_random(5);
		send_frame(5, 1'b0);

		while (out_count < expected_total)
			@(posedge clk_i);
		drive_idle(2 * LINE_BEATS);	// room for any stray output

		if (out_count != expected_total || out_count != exp_q.size())
		begin
			$display("saw %0d outputs, expected %0d, with %0d beats in the expected queue",
				out_count, expected_total, exp_q.size());
			$display("TEST RESULT: FAIL");
			$fatal(1, "output count wrong");
		end
		else
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== debayer.f ====
+incdir+dv
design/debayer_pkg.sv
design/line_writer.sv
design/line_buffer.sv
design/bayer_interp.sv
design/debayer_top.sv
dv/debayer_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f debayer.f --top-module debayer_tb -Mdir obj_dir -o debayer_sim

status=0
result=$(./obj_dir/debayer_sim 2>&1) || status=$?
printf '%s\n' "$result"

if [ "$status" -eq 0 ] && printf '%s\n' "$result" | grep -q '^TEST RESULT: PASS$'; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed"
exit 1
